/* Makefile */
VERILATOR := verilator
TOP       := tb_autotest
FILELIST  := all.f
OBJ_DIR   := obj_dir
LINTFLAGS := --lint-only --timing --assert
SIMFLAGS  := --binary --timing --assert -j 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIMFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

/* all.f */
src/autotest_pkg.sv
src/field_bus_if.sv
src/byte_field_reg.sv
src/run_monitor.sv
src/record_assembler.sv
src/block_sequencer.sv
src/autotest_top.sv
tests/sd_card_model.sv
tests/tb_autotest.sv

/* src/autotest_pkg.sv */
//====================
// shared types, block layout and FSM states of the
// SD vector self-test sequencer, imported by every RTL file
//====================
`default_nettype none

package autotest_pkg;

  typedef logic [7:0]  byte_t;
  typedef logic [31:0] word_t;
  typedef logic [31:0] block_addr_t;
  typedef logic [9:0]  byte_off_t;

  localparam word_t       SIGNATURE   = 32'hAABB_CCDD;
  localparam block_addr_t START_BLOCK = 32'h0010_0000;
  localparam byte_off_t   BLOCK_BYTES = 10'd512;

  // vector and failure record layout
  localparam byte_off_t OFF_SIG    = 10'd0;
  localparam byte_off_t OFF_A      = 10'd4;
  localparam byte_off_t OFF_B      = 10'd8;
  localparam byte_off_t OFF_EXP    = 10'd12;
  localparam byte_off_t OFF_RESULT = 10'd16;
  localparam byte_off_t OFF_CYCLES = 10'd20;

  localparam byte_t FILL_BYTE = 8'hFF;

  typedef enum logic [4:0] {
    ST_SD_RST,
    ST_SD_RST_WAIT,
    ST_IDLE,
    ST_RD_SETUP,
    ST_RD_SETUP_WAIT,
    ST_RD_BYTE,
    ST_RD_WAIT,
    ST_RD_LOAD,
    ST_CHECK_SIG,
    ST_START,
    ST_WAIT_RUN,
    ST_COMPARE,
    ST_DECIDE,
    ST_WR_SETUP,
    ST_WR_SETUP_WAIT,
    ST_WR_LOAD,
    ST_WR_SETTLE,
    ST_WR_BYTE,
    ST_WR_WAIT,
    ST_NEXT_BLOCK,
    ST_HALT
  } seq_state_t;

endpackage

`default_nettype wire

/* src/autotest_top.sv */
//====================
// self-test top: SD host and UUT attach here
//====================
`timescale 1ns/1ps
`default_nettype none

module autotest_top (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      sd_busy_i,
  input  autotest_pkg::byte_t       sd_data_i,
  output logic                      sd_rst_o,
  output logic                      sd_rd_block_o,
  output logic                      sd_rd_byte_o,
  output logic                      sd_wr_block_o,
  output logic                      sd_wr_byte_o,
  output autotest_pkg::block_addr_t sd_block_addr_o,
  output autotest_pkg::byte_t       sd_data_o,
  output logic                      uut_rst_o,
  input  logic                      uut_done_i,
  output autotest_pkg::word_t       uut_a_o,
  output autotest_pkg::word_t       uut_b_o,
  input  autotest_pkg::word_t       uut_result_i,
  output autotest_pkg::word_t       error_count_o,
  output logic                      done_o
);
  import autotest_pkg::*;

  word_t sig_val;
  word_t exp_val;
  word_t result_val;
  word_t cycles_val;
  logic  running;
  logic  capture;
  logic  check;
  logic  emit;
  logic  mismatch;

  field_bus_if u_bus ();

  block_sequencer u_seq (
    .clk(clk), .rst(rst),
    .sd_busy_i(sd_busy_i), .sd_data_i(sd_data_i),
    .sd_rst_o(sd_rst_o), .sd_rd_block_o(sd_rd_block_o), .sd_rd_byte_o(sd_rd_byte_o),
    .sd_wr_block_o(sd_wr_block_o), .sd_wr_byte_o(sd_wr_byte_o),
    .sd_block_addr_o(sd_block_addr_o),
    .uut_rst_o(uut_rst_o), .uut_done_i(uut_done_i),
    .bus(u_bus.seq),
    .running_o(running), .capture_o(capture), .check_o(check), .emit_o(emit),
    .mismatch_i(mismatch), .done_o(done_o)
  );

  // signature is stored MSB first, the rest LSB first
  byte_field_reg #(.field_t(word_t), .BASE_OFF(OFF_SIG), .MSB_FIRST(1'b1)) u_sig (
    .clk(clk), .rst(rst), .bus(u_bus.field), .value_o(sig_val)
  );
  byte_field_reg #(.field_t(word_t), .BASE_OFF(OFF_A), .MSB_FIRST(1'b0)) u_a (
    .clk(clk), .rst(rst), .bus(u_bus.field), .value_o(uut_a_o)
  );
  byte_field_reg #(.field_t(word_t), .BASE_OFF(OFF_B), .MSB_FIRST(1'b0)) u_b (
    .clk(clk), .rst(rst), .bus(u_bus.field), .value_o(uut_b_o)
  );
  byte_field_reg #(.field_t(word_t), .BASE_OFF(OFF_EXP), .MSB_FIRST(1'b0)) u_exp (
    .clk(clk), .rst(rst), .bus(u_bus.field), .value_o(exp_val)
  );

  run_monitor u_mon (
    .clk(clk), .rst(rst),
    .running_i(running), .capture_i(capture), .check_i(check),
    .uut_done_i(uut_done_i), .uut_result_i(uut_result_i), .expected_i(exp_val),
    .result_o(result_val), .cycles_o(cycles_val),
    .mismatch_o(mismatch), .error_count_o(error_count_o)
  );

  record_assembler u_rec (
    .clk(clk), .rst(rst), .bus(u_bus.field), .emit_i(emit),
    .sig_i(sig_val), .a_i(uut_a_o), .b_i(uut_b_o), .exp_i(exp_val),
    .result_i(result_val), .cycles_i(cycles_val),
    .sd_data_o(sd_data_o)
  );

endmodule

`default_nettype wire

/* src/block_sequencer.sv */
//====================
// FSM walking the SD vector blocks: reads each block,
// runs the UUT and writes back a record on a mismatch
//====================
`timescale 1ns/1ps
`default_nettype none

module block_sequencer (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      sd_busy_i,
  input  autotest_pkg::byte_t       sd_data_i,
  output logic                      sd_rst_o,
  output logic                      sd_rd_block_o,
  output logic                      sd_rd_byte_o,
  output logic                      sd_wr_block_o,
  output logic                      sd_wr_byte_o,
  output autotest_pkg::block_addr_t sd_block_addr_o,
  output logic                      uut_rst_o,
  input  logic                      uut_done_i,
  field_bus_if.seq                  bus,
  output logic                      running_o,
  output logic                      capture_o,
  output logic                      check_o,
  output logic                      emit_o,
  input  logic                      mismatch_i,
  output logic                      done_o
);
  import autotest_pkg::*;

  seq_state_t  state_q;
  seq_state_t  state_d;
  byte_off_t   offset_q;
  block_addr_t block_q;
  byte_t       rd_byte_q;
  logic        sig_ok_q;
  logic        last_byte;

  assign last_byte = (offset_q == BLOCK_BYTES - 10'd1);

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      ST_SD_RST:        if (sd_busy_i) state_d = ST_SD_RST_WAIT;
      ST_SD_RST_WAIT:   if (!sd_busy_i) state_d = ST_IDLE;
      ST_IDLE:          state_d = ST_RD_SETUP;
      ST_RD_SETUP:      if (sd_busy_i) state_d = ST_RD_SETUP_WAIT;
      ST_RD_SETUP_WAIT: if (!sd_busy_i) state_d = ST_RD_BYTE;
      ST_RD_BYTE:       if (sd_busy_i) state_d = ST_RD_WAIT;
      ST_RD_WAIT:       if (!sd_busy_i) state_d = ST_RD_LOAD;
      ST_RD_LOAD:       state_d = last_byte ? ST_CHECK_SIG : ST_RD_BYTE;
      ST_CHECK_SIG:     state_d = sig_ok_q ? ST_START : ST_HALT;
      ST_START:         state_d = ST_WAIT_RUN;
      ST_WAIT_RUN:      if (uut_done_i) state_d = ST_COMPARE;
      ST_COMPARE:       state_d = ST_DECIDE;
      // mismatch is registered by the monitor during COMPARE
      ST_DECIDE:        state_d = mismatch_i ? ST_WR_SETUP : ST_NEXT_BLOCK;
      ST_WR_SETUP:      if (sd_busy_i) state_d = ST_WR_SETUP_WAIT;
      ST_WR_SETUP_WAIT: if (!sd_busy_i) state_d = ST_WR_LOAD;
      ST_WR_LOAD:       state_d = ST_WR_SETTLE;
      ST_WR_SETTLE:     state_d = ST_WR_BYTE;
      ST_WR_BYTE:       if (sd_busy_i) state_d = ST_WR_WAIT;
      ST_WR_WAIT: begin
        if (!sd_busy_i) begin
          state_d = last_byte ? ST_NEXT_BLOCK : ST_WR_LOAD;
        end
      end
      ST_NEXT_BLOCK:    state_d = ST_IDLE;
      ST_HALT:          state_d = ST_HALT;
      default:          state_d = ST_HALT;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= ST_SD_RST;
    end else begin
      state_q <= state_d;
    end
  end

  // byte offset, block address and running signature check
  always_ff @(posedge clk) begin
    if (rst) begin
      offset_q <= '0;
      block_q  <= START_BLOCK;
      sig_ok_q <= 1'b0;
    end else begin
      case (state_q)
        ST_IDLE: begin
          offset_q <= '0;
          sig_ok_q <= 1'b1;
        end
        ST_RD_LOAD: begin
          offset_q <= offset_q + 1'b1;
          if (offset_q < OFF_A &&
              rd_byte_q != SIGNATURE[{~offset_q[1:0], 3'b000} +: 8]) begin
            sig_ok_q <= 1'b0;
          end
        end
        ST_DECIDE: offset_q <= '0;
        ST_WR_WAIT: begin
          if (!sd_busy_i) begin
            offset_q <= offset_q + 1'b1;
          end
        end
        ST_NEXT_BLOCK: block_q <= block_q + 1'b1;
        default: ;
      endcase
    end
  end

  // read data is valid on the cycle busy falls
  always_ff @(posedge clk) begin
    if (state_q == ST_RD_WAIT && !sd_busy_i) begin
      rd_byte_q <= sd_data_i;
    end
  end

  assign sd_rst_o      = (state_q == ST_SD_RST);
  assign sd_rd_block_o = (state_q == ST_RD_SETUP) || (state_q == ST_RD_SETUP_WAIT) ||
                         (state_q == ST_RD_BYTE) || (state_q == ST_RD_WAIT) ||
                         (state_q == ST_RD_LOAD);
  assign sd_rd_byte_o  = (state_q == ST_RD_BYTE);
  assign sd_wr_block_o = (state_q == ST_WR_SETUP) || (state_q == ST_WR_SETUP_WAIT) ||
                         (state_q == ST_WR_LOAD) || (state_q == ST_WR_SETTLE) ||
                         (state_q == ST_WR_BYTE) || (state_q == ST_WR_WAIT);
  assign sd_wr_byte_o  = (state_q == ST_WR_BYTE);
  assign sd_block_addr_o = block_q;

  assign running_o = (state_q == ST_START) || (state_q == ST_WAIT_RUN);
  assign uut_rst_o = ~running_o;
  assign capture_o = (state_q == ST_WAIT_RUN) && uut_done_i;
  assign check_o   = (state_q == ST_COMPARE);
  assign emit_o    = (state_q == ST_WR_LOAD);
  assign done_o    = (state_q == ST_HALT);

  assign bus.offset  = offset_q;
  assign bus.rd_byte = rd_byte_q;
  assign bus.load    = (state_q == ST_RD_LOAD);
  assign bus.clear   = (state_q == ST_IDLE);

endmodule

`default_nettype wire

/* src/byte_field_reg.sv */
//====================
// one vector field, filled byte by byte from the
// block stream at its own offset and byte order
//====================
`timescale 1ns/1ps
`default_nettype none

module byte_field_reg #(
  parameter type                   field_t   = autotest_pkg::word_t,
  parameter autotest_pkg::byte_off_t BASE_OFF  = 10'd0,
  parameter bit                    MSB_FIRST = 1'b0
) (
  input  logic       clk,
  input  logic       rst,
  field_bus_if.field bus,
  output field_t     value_o
);
  import autotest_pkg::*;

  byte_off_t                 rel;
  logic                      hit;
  int                        lane;
  logic [$bits(field_t)-1:0] field_q;

  // offset inside the field, only meaningful on a hit
  always_comb begin
    rel  = bus.offset - BASE_OFF;
    hit  = (bus.offset >= BASE_OFF) && (int'(rel) < $bits(field_t) / 8);
    lane = MSB_FIRST ? ($bits(field_t) / 8 - 1 - int'(rel)) : int'(rel);
  end

  always_ff @(posedge clk) begin
    if (rst || bus.clear) begin
      field_q <= '0;
    end else if (bus.load && hit) begin
      field_q[lane*8 +: 8] <= bus.rd_byte;
    end
  end

  assign value_o = field_t'(field_q);

endmodule

`default_nettype wire

/* src/field_bus_if.sv */
//====================
// block byte stream from the sequencer to the field
// registers and the record assembler
//====================
`timescale 1ns/1ps
`default_nettype none

interface field_bus_if;
  import autotest_pkg::*;

  byte_off_t offset;
  byte_t     rd_byte;
  logic      load;
  logic      clear;

  modport seq (output offset, output rd_byte, output load, output clear);
  modport field (input offset, input rd_byte, input load, input clear);

endinterface

`default_nettype wire

/* src/record_assembler.sv */
//====================
// builds the failure record one byte at a time
// for the SD block write
//====================
`timescale 1ns/1ps
`default_nettype none

module record_assembler (
  input  logic                clk,
  input  logic                rst,
  field_bus_if.field          bus,
  input  logic                emit_i,
  input  autotest_pkg::word_t sig_i,
  input  autotest_pkg::word_t a_i,
  input  autotest_pkg::word_t b_i,
  input  autotest_pkg::word_t exp_i,
  input  autotest_pkg::word_t result_i,
  input  autotest_pkg::word_t cycles_i,
  output autotest_pkg::byte_t sd_data_o
);
  import autotest_pkg::*;

  logic [1:0] lane;
  byte_t      byte_d;
  byte_t      byte_q;

  // all fields are word aligned, signature goes out MSB first
  always_comb begin
    lane = bus.offset[1:0];
    if (bus.offset < OFF_A) begin
      byte_d = sig_i[{~lane, 3'b000} +: 8];
    end else if (bus.offset < OFF_B) begin
      byte_d = a_i[{lane, 3'b000} +: 8];
    end else if (bus.offset < OFF_EXP) begin
      byte_d = b_i[{lane, 3'b000} +: 8];
    end else if (bus.offset < OFF_RESULT) begin
      byte_d = exp_i[{lane, 3'b000} +: 8];
    end else if (bus.offset < OFF_CYCLES) begin
      byte_d = result_i[{lane, 3'b000} +: 8];
    end else if (bus.offset < OFF_CYCLES + 10'd4) begin
      byte_d = cycles_i[{lane, 3'b000} +: 8];
    end else begin
      byte_d = FILL_BYTE;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      byte_q <= FILL_BYTE;
    end else if (emit_i) begin
      byte_q <= byte_d;
    end
  end

  assign sd_data_o = byte_q;

endmodule

`default_nettype wire

/* src/run_monitor.sv */
//====================
// times the UUT run, captures and checks its result
// and keeps the error count
//====================
`timescale 1ns/1ps
`default_nettype none

module run_monitor (
  input  logic                clk,
  input  logic                rst,
  input  logic                running_i,
  input  logic                capture_i,
  input  logic                check_i,
  input  logic                uut_done_i,
  input  autotest_pkg::word_t uut_result_i,
  input  autotest_pkg::word_t expected_i,
  output autotest_pkg::word_t result_o,
  output autotest_pkg::word_t cycles_o,
  output logic                mismatch_o,
  output autotest_pkg::word_t error_count_o
);
  import autotest_pkg::*;

  logic  running_q;
  logic  mismatch_q;
  word_t cycles_q;
  word_t result_q;
  word_t errors_q;

  // count restarts as the UUT leaves reset for a new block
  always_ff @(posedge clk) begin
    if (rst) begin
      running_q <= 1'b0;
      cycles_q  <= '0;
    end else begin
      running_q <= running_i;
      if (running_i && !running_q) begin
        cycles_q <= uut_done_i ? word_t'(0) : word_t'(1);
      end else if (running_i && !uut_done_i) begin
        cycles_q <= cycles_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (capture_i) begin
      result_q <= uut_result_i;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      mismatch_q <= 1'b0;
      errors_q   <= '0;
    end else if (check_i) begin
      mismatch_q <= (result_q != expected_i);
      if (result_q != expected_i) begin
        errors_q <= errors_q + 1'b1;
      end
    end
  end

  assign result_o      = result_q;
  assign cycles_o      = cycles_q;
  assign mismatch_o    = mismatch_q;
  assign error_count_o = errors_q;

endmodule

`default_nettype wire

/* tests/autotest_trace.txt */
# signature operand_a operand_b expected uut_result (hex), uut_delay (cycles, decimal)
# one line per block from START_BLOCK on, the last line is the bad-signature block
aabbccdd 00000003 00000004 00000007 00000007 3
aabbccdd 12345678 11111111 23456789 23456789 1
aabbccdd ffffffff 00000001 00000000 00000001 5
aabbccdd 0badf00d 10000000 1badf00d 1badf00d 12
aabbccdd 80000000 80000000 00000000 deadbeef 2
aabbccdd 01020304 05060708 06080a0c 06080a0c 7
aabbccdd 7fffffff 00000001 80000000 80000000 1
aabbccdd 00c0ffee 00001000 00c10fee 00c10fff 9
aabbccde 00000000 00000000 00000000 00000000 1

/* tests/sd_card_model.sv */
//====================
// SD/SPI host model: block memory, random busy length
// and per-block read and write counts for the testbench
//====================
`timescale 1ns/1ps
`default_nettype none

module sd_card_model #(
  parameter int MAX_BLOCKS = 16,
  parameter int BUSY_BITS  = 3
) (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      sd_rst_i,
  input  logic                      rd_block_i,
  input  logic                      rd_byte_i,
  input  logic                      wr_block_i,
  input  logic                      wr_byte_i,
  input  autotest_pkg::block_addr_t block_addr_i,
  input  autotest_pkg::byte_t       wr_data_i,
  output logic                      busy_o,
  output autotest_pkg::byte_t       rd_data_o,
  output int                        fault_o
);
  import autotest_pkg::*;

  typedef enum int {OP_NONE, OP_CMD, OP_RD, OP_WR} op_t;

  byte_t       mem [MAX_BLOCKS*512];
  int          rd_count [MAX_BLOCKS];
  int          wr_count [MAX_BLOCKS];
  int          wr_bytes [MAX_BLOCKS];
  logic [15:0] lfsr;
  op_t         op;
  int          busy_left;
  int          blk;
  int          pos;
  logic        blk_open;
  byte_t       wr_latch;

  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  // one LFSR step per bit of the busy length
  task automatic draw_busy();
    busy_left = 0;
    for (int i = 0; i < BUSY_BITS; i++) begin
      lfsr      = lfsr_step(lfsr);
      busy_left = (busy_left << 1) | int'(lfsr[0]);
    end
  endtask

  task automatic load_byte(input int idx, input byte_t value);
    mem[idx] = value;
  endtask

  task automatic open_block(input logic is_write);
    blk_open = 1'b1;
    pos      = 0;
    blk      = 0;
    if (block_addr_i < START_BLOCK || block_addr_i - START_BLOCK >= 32'(MAX_BLOCKS)) begin
      fault_o <= 2;
    end else begin
      blk = int'(block_addr_i - START_BLOCK);
      if (is_write) wr_count[blk]++;
      else rd_count[blk]++;
    end
  endtask

  initial begin
    busy_o    = 1'b0;
    rd_data_o = '0;
    fault_o   = 0;
  end

  always @(posedge clk) begin
    if (rst) begin
      busy_o    <= 1'b0;
      rd_data_o <= '0;
      fault_o   <= 0;
      lfsr      = 16'd89;
      op        = OP_NONE;
      blk_open  = 1'b0;
    end else if (busy_o) begin
      // write data has to hold until busy drops
      if (op == OP_WR && wr_data_i != wr_latch) fault_o <= 1;
      if (busy_left > 0) begin
        busy_left--;
      end else begin
        busy_o <= 1'b0;
        if (op == OP_RD) begin
          rd_data_o <= mem[blk*512 + pos];
          pos++;
        end else if (op == OP_WR) begin
          mem[blk*512 + pos] = wr_latch;
          wr_bytes[blk]++;
          pos++;
        end
      end
    end else begin
      if (!rd_block_i && !wr_block_i) blk_open = 1'b0;
      op = OP_NONE;
      if (sd_rst_i) begin
        op = OP_CMD;
      end else if ((rd_block_i || wr_block_i) && !blk_open) begin
        open_block(wr_block_i);
        op = OP_CMD;
      end else if (rd_byte_i || wr_byte_i) begin
        if (!blk_open || pos >= 512 || (rd_byte_i && !rd_block_i) ||
            (wr_byte_i && !wr_block_i)) begin
          fault_o <= 3;
        end
        op       = rd_byte_i ? OP_RD : OP_WR;
        wr_latch = wr_data_i;
      end
      if (op != OP_NONE) begin
        busy_o <= 1'b1;
        draw_busy();
      end
    end
  end

endmodule

`default_nettype wire

/* tests/tb_autotest.sv */
//====================
// testbench: replays the vector trace through the SD host
// model and a UUT model, then checks the failure records
//====================
`timescale 1ns/1ps
`default_nettype none

module tb_autotest;
  import autotest_pkg::*;

  localparam int CLK_PERIOD   = 8;
  localparam int MAX_BLOCKS   = 16;
  localparam int BUSY_BITS    = 3;
  localparam int MAX_BUSY     = 1 << BUSY_BITS;
  localparam int QUIET_CYCLES = 2000;

  logic        clk;
  logic        rst;
  logic        sd_busy;
  byte_t       sd_rd_data;
  logic        sd_rst;
  logic        sd_rd_block;
  logic        sd_rd_byte;
  logic        sd_wr_block;
  logic        sd_wr_byte;
  block_addr_t sd_block_addr;
  byte_t       sd_wr_data;
  logic        uut_rst;
  logic        uut_done;
  word_t       uut_a;
  word_t       uut_b;
  word_t       uut_result;
  word_t       error_count;
  logic        done;
  int          sd_fault;

  word_t sig_v [MAX_BLOCKS];
  word_t a_v [MAX_BLOCKS];
  word_t b_v [MAX_BLOCKS];
  word_t exp_v [MAX_BLOCKS];
  word_t res_v [MAX_BLOCKS];
  int    delay_v [MAX_BLOCKS];
  int    cycles_v [MAX_BLOCKS];
  int    num_blocks;
  int    num_good;
  int    expected_errors;
  int    runs_started;
  int    cur_vec;
  int    run_cycles;
  int    elapsed;
  bit    run_active;
  bit    trace_loaded;

  autotest_top u_dut (
    .clk(clk), .rst(rst),
    .sd_busy_i(sd_busy), .sd_data_i(sd_rd_data),
    .sd_rst_o(sd_rst), .sd_rd_block_o(sd_rd_block), .sd_rd_byte_o(sd_rd_byte),
    .sd_wr_block_o(sd_wr_block), .sd_wr_byte_o(sd_wr_byte),
    .sd_block_addr_o(sd_block_addr), .sd_data_o(sd_wr_data),
    .uut_rst_o(uut_rst), .uut_done_i(uut_done),
    .uut_a_o(uut_a), .uut_b_o(uut_b), .uut_result_i(uut_result),
    .error_count_o(error_count), .done_o(done)
  );

  sd_card_model #(.MAX_BLOCKS(MAX_BLOCKS), .BUSY_BITS(BUSY_BITS)) u_sd (
    .clk(clk), .rst(rst),
    .sd_rst_i(sd_rst), .rd_block_i(sd_rd_block), .rd_byte_i(sd_rd_byte),
    .wr_block_i(sd_wr_block), .wr_byte_i(sd_wr_byte),
    .block_addr_i(sd_block_addr), .wr_data_i(sd_wr_data),
    .busy_o(sd_busy), .rd_data_o(sd_rd_data), .fault_o(sd_fault)
  );

  initial clk = 1'b0;
  always #(CLK_PERIOD / 2) clk = ~clk;

  task automatic fail_now(input string what);
    $display("%s", what);
    $display("Some tests failed");
    $fatal(1);
  endtask

  task automatic value_error(input string name, input word_t got, input word_t want);
    fail_now($sformatf("[ERROR] %0t ns: %s is %h, expected %h", $time, name, got, want));
  endtask

  function automatic string fault_text(input int code);
    case (code)
      1: return "SD write data changed while the host was busy";
      2: return "SD block address outside the model memory";
      default: return "SD byte request outside an open block";
    endcase
  endfunction

  // vector block and failure record share bytes 0..15
  function automatic byte_t record_byte(input int v, input int off);
    word_t field;
    case (off / 4)
      0: field = sig_v[v];
      1: field = a_v[v];
      2: field = b_v[v];
      3: field = exp_v[v];
      4: field = res_v[v];
      5: field = word_t'(cycles_v[v]);
      default: field = 32'hFFFF_FFFF;
    endcase
    if (off < 4) begin
      return byte_t'(field >> (8 * (3 - off)));
    end
    return byte_t'(field >> (8 * (off % 4)));
  endfunction

  function automatic byte_t fill_byte(input longint addr);
    return byte_t'(addr ^ (addr >> 8) ^ (addr >> 16) ^ (addr >> 24) ^ (addr >> 32));
  endfunction

  task automatic load_trace();
    int    fd;
    int    v;
    int    off;
    int    d;
    string line;
    word_t s;
    word_t a;
    word_t b;
    word_t e;
    word_t r;
    fd = $fopen("tests/autotest_trace.txt", "r");
    assert (fd != 0) else fail_now("cannot open the trace file tests/autotest_trace.txt");
    num_blocks = 0;
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() > 0 && line[0] != "#" &&
          $sscanf(line, "%h %h %h %h %h %d", s, a, b, e, r, d) == 6) begin
        assert (num_blocks < MAX_BLOCKS) else fail_now("trace holds too many blocks");
        sig_v[num_blocks]   = s;
        a_v[num_blocks]     = a;
        b_v[num_blocks]     = b;
        exp_v[num_blocks]   = e;
        res_v[num_blocks]   = r;
        delay_v[num_blocks] = d;
        num_blocks++;
      end
    end
    $fclose(fd);
    num_good        = num_blocks - 1;
    expected_errors = 0;
    assert (num_good > 0 && sig_v[num_good] != 32'hAABB_CCDD)
      else fail_now("trace must end with one bad-signature block");
    for (v = 0; v < num_good; v++) begin
      assert (sig_v[v] == 32'hAABB_CCDD) else fail_now("bad signature before the last trace block");
      if (res_v[v] != exp_v[v]) expected_errors++;
    end
    for (v = 0; v < num_blocks; v++) begin
      for (off = 0; off < 512; off++) begin
        if (off < 16) u_sd.load_byte(v * 512 + off, record_byte(v, off));
        else u_sd.load_byte(v * 512 + off, fill_byte((longint'(START_BLOCK) + v) * 512 + off));
      end
    end
  endtask

  task automatic check_records();
    int    v;
    int    off;
    byte_t got;
    byte_t want;
    for (v = 0; v < num_good; v++) begin
      assert (u_sd.rd_count[v] == 1)
        else fail_now($sformatf("vector block %0d was read %0d times", v, u_sd.rd_count[v]));
      if (res_v[v] == exp_v[v]) begin
        assert (u_sd.wr_count[v] == 0)
          else fail_now($sformatf("record written for passing vector %0d", v));
      end else begin
        assert (u_sd.wr_count[v] == 1 && u_sd.wr_bytes[v] == 512)
          else fail_now($sformatf("vector %0d: %0d record writes with %0d bytes in all",
                                  v, u_sd.wr_count[v], u_sd.wr_bytes[v]));
        for (off = 0; off < 512; off++) begin
          got  = u_sd.mem[v * 512 + off];
          want = record_byte(v, off);
          assert (got == want)
            else value_error($sformatf("sd_data_o block %0d byte %0d", v, off),
                             word_t'(got), word_t'(want));
        end
      end
    end
    assert (u_sd.wr_count[num_good] == 0) else fail_now("record written over the bad block");
  endtask

  // UUT model with its own cycle count, sampled on the rising edge
  always @(posedge clk) begin
    if (rst || uut_rst) begin
      run_active = 1'b0;
      uut_done <= 1'b0;
    end else begin
      if (!run_active) begin
        run_active   = 1'b1;
        cur_vec      = runs_started;
        runs_started = runs_started + 1;
        run_cycles   = 0;
        elapsed      = 0;
        assert (cur_vec < num_good) else fail_now("UUT released for a block past the last vector");
      end
      if (!uut_done) run_cycles = run_cycles + 1;
      elapsed           = elapsed + 1;
      cycles_v[cur_vec] = run_cycles;
      uut_done   <= (elapsed >= delay_v[cur_vec]);
      uut_result <= res_v[cur_vec];
      assert (uut_a == a_v[cur_vec]) else value_error("uut_a_o", uut_a, a_v[cur_vec]);
      assert (uut_b == b_v[cur_vec]) else value_error("uut_b_o", uut_b, b_v[cur_vec]);
      assert (sd_block_addr == START_BLOCK + word_t'(cur_vec))
        else value_error("sd_block_addr_o", sd_block_addr, START_BLOCK + word_t'(cur_vec));
    end
  end

  always @(negedge clk) begin
    if (!rst) begin
      assert (sd_fault == 0) else fail_now(fault_text(sd_fault));
    end
  end

  initial begin
    wait (trace_loaded);
    #(num_blocks * 1100 * (MAX_BUSY + 4) * CLK_PERIOD);
    fail_now("watchdog expired before the sequencer reached done");
  end

  initial begin
    rst        = 1'b1;
    uut_done   = 1'b0;
    uut_result = '0;
    load_trace();
    trace_loaded = 1'b1;
    repeat (3) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    assert (!sd_rd_block) else value_error("sd_rd_block_o", word_t'(sd_rd_block), 32'd0);
    assert (!sd_wr_block) else value_error("sd_wr_block_o", word_t'(sd_wr_block), 32'd0);
    assert (!done) else value_error("done_o", word_t'(done), 32'd0);
    assert (error_count == 0) else value_error("error_count_o", error_count, 32'd0);
    assert (uut_rst) else value_error("uut_rst_o", word_t'(uut_rst), 32'd1);
    while (done !== 1'b1) @(negedge clk);
    assert (runs_started == num_good)
      else fail_now($sformatf("halted after %0d UUT runs, trace has %0d", runs_started, num_good));
    assert (u_sd.rd_count[num_good] == 1) else fail_now("bad-signature block not read once");
    // halted for good, nothing may move on the SD side
    repeat (QUIET_CYCLES) begin
      @(negedge clk);
      assert (!sd_rd_block && !sd_wr_block && !sd_rst && done)
        else fail_now("SD request or done drop after the sequencer halted");
    end
    assert (error_count == word_t'(expected_errors))
      else value_error("error_count_o", error_count, word_t'(expected_errors));
    check_records();
    $display("All tests passed");
    $finish;
  end

endmodule

`default_nettype wire
